//--- rtl/flashPkg.sv
package flashPkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 8;

    // Host command codes as seen on i_Cmd
    typedef enum logic [2:0] {
        WriteEnable = 3'd0,
        SectorErase = 3'd1,
        BlockErase  = 3'd2,
        ChipErase   = 3'd3,
        ProgramPage = 3'd4,
        Read        = 3'd5,
        ReadSr      = 3'd6,
        WriteSr     = 3'd7
    } cmdT;

    // Flash opcodes, single lane
    localparam logic [DATA_W-1:0] OP_WRITE_ENABLE = 8'h06;
    localparam logic [DATA_W-1:0] OP_SECTOR_ERASE = 8'h20;
    localparam logic [DATA_W-1:0] OP_BLOCK_ERASE  = 8'hD8;
    localparam logic [DATA_W-1:0] OP_CHIP_ERASE   = 8'hC7;
    localparam logic [DATA_W-1:0] OP_PAGE_PROGRAM = 8'h02;
    localparam logic [DATA_W-1:0] OP_READ         = 8'h03;

    // Status register 1..3 access
    localparam logic [DATA_W-1:0] OP_READ_SR1  = 8'h05;
    localparam logic [DATA_W-1:0] OP_READ_SR2  = 8'h35;
    localparam logic [DATA_W-1:0] OP_READ_SR3  = 8'h15;
    localparam logic [DATA_W-1:0] OP_WRITE_SR1 = 8'h01;
    localparam logic [DATA_W-1:0] OP_WRITE_SR2 = 8'h31;
    localparam logic [DATA_W-1:0] OP_WRITE_SR3 = 8'h11;

    // Idle flash clocks between the last address bit and the first read bit
    localparam int unsigned READ_TURNAROUND = 1;

    typedef enum logic [1:0] {
        Idle,
        Tx,
        Rx
    } seqStateT;

endpackage

//--- rtl/flashShiftIf.sv
`timescale 1ns/1ns

interface flashShiftIf import flashPkg::*; ();

    logic              load;
    logic [DATA_W-1:0] loadByte;
    logic              shiftOut;
    logic              shiftIn;
    logic              driveOut;
    logic              clkEn;
    logic              wpDrive;
    logic              captureRead;
    // Live content of the byte shift register
    logic [DATA_W-1:0] curByte;

    modport Sequencer (
        output load, loadByte, shiftOut, shiftIn,
        output driveOut, clkEn, wpDrive, captureRead,
        input  curByte
    );

    modport Shifter (
        input  load, loadByte, shiftOut, shiftIn,
        input  driveOut, clkEn, wpDrive, captureRead,
        output curByte
    );

endinterface

//--- rtl/flashCountIf.sv
`timescale 1ns/1ns

interface flashCountIf ();

    logic       cntClear;
    logic       bitStep;
    logic       addrStep;
    logic       waitLoad;
    logic       waitStep;
    logic [2:0] bitIdx;
    logic       bitSix;
    logic       bitSeven;
    logic       addrDone;
    logic       waitZero;

    modport Sequencer (
        output cntClear, bitStep, addrStep, waitLoad, waitStep,
        input  bitIdx, bitSix, bitSeven, addrDone, waitZero
    );

    modport Counter (
        input  cntClear, bitStep, addrStep, waitLoad, waitStep,
        output bitIdx, bitSix, bitSeven, addrDone, waitZero
    );

endinterface

//--- rtl/flashBitCounter.sv
`timescale 1ns/1ns

module flashBitCounter import flashPkg::*; (
    input  logic         i_Clk,
    input  logic         i_arstN,
    flashCountIf.Counter cnt
);

    // Address bytes already loaded into the shifter
    logic [1:0] addrCnt;
    // Remaining turnaround cycles before read sampling starts
    logic [2:0] waitCnt;

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            cnt.bitIdx <= '0;
            addrCnt    <= '0;
            waitCnt    <= '0;
        end else if (cnt.cntClear) begin
            cnt.bitIdx <= '0;
            addrCnt    <= '0;
            waitCnt    <= '0;
        end else begin
            // Wraps from 7 back to 0 at each byte boundary
            if (cnt.bitStep) begin
                cnt.bitIdx <= cnt.bitIdx + 3'd1;
            end
            if (cnt.addrStep) begin
                addrCnt <= addrCnt + 2'd1;
            end
            if (cnt.waitLoad) begin
                waitCnt <= 3'(READ_TURNAROUND);
            end else if (cnt.waitStep) begin
                waitCnt <= waitCnt - 3'd1;
            end
        end
    end

    assign cnt.bitSix   = (cnt.bitIdx == 3'd6);
    assign cnt.bitSeven = (cnt.bitIdx == 3'd7);
    // All three address bytes have been handed to the shifter
    assign cnt.addrDone = (addrCnt == 2'd3);
    assign cnt.waitZero = (waitCnt == 3'd0);

endmodule

//--- rtl/flashShifter.sv
`timescale 1ns/1ns

module flashShifter import flashPkg::*; (
    input  logic              i_Clk,
    input  logic              i_arstN,
    flashShiftIf.Shifter      sh,
    input  logic              i_FlashMiso,
    output logic              o_FlashClk,
    inout  logic [3:0]        io_FlashIo,
    output logic [DATA_W-1:0] o_ReadData
);

    logic io0Out;
    logic io0Oe;
    logic wpOe;
    logic clkEnReg;

    // Output enables and clock gate
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            io0Oe    <= 1'b0;
            wpOe     <= 1'b0;
            clkEnReg <= 1'b0;
        end else begin
            io0Oe    <= sh.driveOut;
            wpOe     <= sh.wpDrive;
            clkEnReg <= sh.clkEn;
        end
    end

    // Byte shift register, MSB first in both directions
    always_ff @(posedge i_Clk) begin
        if (sh.shiftOut) begin
            io0Out <= sh.curByte[DATA_W-1];
        end

        // A load on bit 7 replaces the byte while its last bit goes out
        if (sh.load) begin
            sh.curByte <= sh.loadByte;
        end else if (sh.shiftOut) begin
            sh.curByte <= {sh.curByte[DATA_W-2:0], 1'b0};
        end else if (sh.shiftIn) begin
            sh.curByte <= {sh.curByte[DATA_W-2:0], i_FlashMiso};
        end

        if (sh.captureRead) begin
            o_ReadData <= {sh.curByte[DATA_W-2:0], i_FlashMiso};
        end
    end

    // Flash clock rises mid-cycle so IO0 is stable when it is sampled
    assign o_FlashClk = clkEnReg & ~i_Clk;

    // IO0 is data out, IO1 is data in, IO2 is held high as write protect
    assign io_FlashIo[0] = io0Oe ? io0Out : 1'bz;
    assign io_FlashIo[1] = 1'bz;
    assign io_FlashIo[2] = wpOe ? 1'b1 : 1'bz;
    assign io_FlashIo[3] = 1'bz;

endmodule

//--- rtl/flashSequencer.sv
`timescale 1ns/1ns

module flashSequencer import flashPkg::*; (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic              i_CmdEn,
    input  cmdT               i_Cmd,
    input  logic [ADDR_W-1:0] i_Addr,
    input  logic [DATA_W-1:0] i_WriteData,
    input  logic              i_AckReq,
    output logic              o_ReqNextData,
    output logic              o_NewDataNextClk,
    output logic              o_CmdBusy,
    output logic              o_FlashNcs,
    flashShiftIf.Sequencer    sh,
    flashCountIf.Sequencer    cnt
);

    seqStateT state;
    seqStateT stateNext;

    // Per-transaction flags captured at acceptance
    logic needAddr;
    logic hostDep;
    logic recvData;
    logic wpHold;
    logic [ADDR_W-1:0] addrReg;

    logic [DATA_W-1:0] decOp;
    logic decAddr;
    logic decHostDep;
    logic decRecv;
    logic decWp;
    logic accept;
    logic hostWrite;

    function automatic logic [DATA_W-1:0] srOpcode(input logic [1:0] sel, input logic wr);
        logic [DATA_W-1:0] op;
        case (sel)
            2'd2:    op = wr ? OP_WRITE_SR2 : OP_READ_SR2;
            2'd3:    op = wr ? OP_WRITE_SR3 : OP_READ_SR3;
            default: op = wr ? OP_WRITE_SR1 : OP_READ_SR1;
        endcase
        return op;
    endfunction

    always_comb begin
        decOp      = OP_WRITE_ENABLE;
        decAddr    = 1'b0;
        decHostDep = 1'b0;
        decRecv    = 1'b0;
        decWp      = 1'b0;
        case (i_Cmd)
            WriteEnable: begin
                decOp = OP_WRITE_ENABLE;
                decWp = 1'b1;
            end
            SectorErase: begin
                decOp   = OP_SECTOR_ERASE;
                decAddr = 1'b1;
            end
            BlockErase: begin
                decOp   = OP_BLOCK_ERASE;
                decAddr = 1'b1;
            end
            ChipErase: decOp = OP_CHIP_ERASE;
            ProgramPage: begin
                decOp      = OP_PAGE_PROGRAM;
                decAddr    = 1'b1;
                decHostDep = 1'b1;
            end
            Read: begin
                decOp      = OP_READ;
                decAddr    = 1'b1;
                decHostDep = 1'b1;
                decRecv    = 1'b1;
            end
            ReadSr: begin
                decOp   = srOpcode(i_Addr[1:0], 1'b0);
                decRecv = 1'b1;
            end
            WriteSr: begin
                decOp      = srOpcode(i_Addr[1:0], 1'b1);
                decHostDep = 1'b1;
            end
            default: decOp = OP_WRITE_ENABLE;
        endcase
    end

    // nCS still low means the previous frame has not closed yet
    assign accept    = (state == Idle) && i_CmdEn && o_FlashNcs;
    // Current byte may be followed by a host data byte
    assign hostWrite = hostDep && !recvData && (!needAddr || cnt.addrDone);

    assign o_CmdBusy        = i_CmdEn || !o_FlashNcs;
    assign o_ReqNextData    = (state == Tx) && cnt.bitSix && hostWrite;
    assign o_NewDataNextClk = (state == Rx) && cnt.waitZero && cnt.bitSeven && hostDep;

    always_comb begin
        stateNext      = state;
        sh.load        = 1'b0;
        sh.loadByte    = decOp;
        sh.shiftOut    = 1'b0;
        sh.shiftIn     = 1'b0;
        sh.driveOut    = 1'b0;
        sh.clkEn       = 1'b0;
        sh.captureRead = 1'b0;
        sh.wpDrive     = (state == Idle) ? (accept && decWp) : wpHold;
        cnt.cntClear   = 1'b0;
        cnt.bitStep    = 1'b0;
        cnt.addrStep   = 1'b0;
        cnt.waitLoad   = 1'b0;
        cnt.waitStep   = 1'b0;
        case (state)
            Idle: begin
                if (accept) begin
                    stateNext    = Tx;
                    sh.load      = 1'b1;
                    cnt.cntClear = 1'b1;
                end
            end
            Tx: begin
                sh.shiftOut = 1'b1;
                sh.driveOut = 1'b1;
                sh.clkEn    = 1'b1;
                cnt.bitStep = 1'b1;
                // Pick what follows once the last bit of this byte is out
                if (cnt.bitSeven) begin
                    if (needAddr && !cnt.addrDone) begin
                        sh.load      = 1'b1;
                        sh.loadByte  = addrReg[ADDR_W-1 -: DATA_W];
                        cnt.addrStep = 1'b1;
                    end else if (hostWrite && i_AckReq) begin
                        sh.load     = 1'b1;
                        sh.loadByte = i_WriteData;
                    end else if (recvData) begin
                        stateNext    = Rx;
                        cnt.waitLoad = 1'b1;
                    end else begin
                        stateNext = Idle;
                    end
                end
            end
            Rx: begin
                sh.clkEn = 1'b1;
                if (!cnt.waitZero) begin
                    cnt.waitStep = 1'b1;
                end else begin
                    sh.shiftIn  = 1'b1;
                    cnt.bitStep = 1'b1;
                    if (cnt.bitSeven) begin
                        sh.captureRead = 1'b1;
                        if (!(hostDep && i_AckReq)) begin
                            stateNext = Idle;
                        end
                    end
                end
            end
            default: stateNext = Idle;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state      <= Idle;
            o_FlashNcs <= 1'b1;
            needAddr   <= 1'b0;
            hostDep    <= 1'b0;
            recvData   <= 1'b0;
            wpHold     <= 1'b0;
        end else begin
            state <= stateNext;
            // nCS stays low through the cycle after the last bit
            if (accept) begin
                o_FlashNcs <= 1'b0;
                needAddr   <= decAddr;
                hostDep    <= decHostDep;
                recvData   <= decRecv;
                wpHold     <= decWp;
            end else if (state == Idle) begin
                o_FlashNcs <= 1'b1;
            end
        end
    end

    // Address bytes leave MSB first
    always_ff @(posedge i_Clk) begin
        if (accept) begin
            addrReg <= i_Addr;
        end else if (cnt.addrStep) begin
            addrReg <= addrReg << DATA_W;
        end
    end

endmodule

//--- rtl/flashController.sv
`timescale 1ns/1ns

module flashController import flashPkg::*; (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic              i_CmdEn,
    input  logic [2:0]        i_Cmd,
    input  logic [ADDR_W-1:0] i_Addr,
    input  logic [DATA_W-1:0] i_WriteData,
    input  logic              i_AckReq,
    output logic [DATA_W-1:0] o_ReadData,
    output logic              o_ReqNextData,
    output logic              o_NewDataNextClk,
    output logic              o_CmdBusy,
    output logic              o_FlashClk,
    output logic              o_FlashNcs,
    inout  logic [3:0]        io_FlashIo
);

    flashShiftIf shIf ();
    flashCountIf cntIf ();

    flashSequencer flashSequencer_inst (
        .i_Clk            (i_Clk),
        .i_arstN          (i_arstN),
        .i_CmdEn          (i_CmdEn),
        .i_Cmd            (cmdT'(i_Cmd)),
        .i_Addr           (i_Addr),
        .i_WriteData      (i_WriteData),
        .i_AckReq         (i_AckReq),
        .o_ReqNextData    (o_ReqNextData),
        .o_NewDataNextClk (o_NewDataNextClk),
        .o_CmdBusy        (o_CmdBusy),
        .o_FlashNcs       (o_FlashNcs),
        .sh               (shIf.Sequencer),
        .cnt              (cntIf.Sequencer)
    );

    flashBitCounter flashBitCounter_inst (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .cnt     (cntIf.Counter)
    );

    // Read data comes back on IO1
    flashShifter flashShifter_inst (
        .i_Clk       (i_Clk),
        .i_arstN     (i_arstN),
        .sh          (shIf.Shifter),
        .i_FlashMiso (io_FlashIo[1]),
        .o_FlashClk  (o_FlashClk),
        .io_FlashIo  (io_FlashIo),
        .o_ReadData  (o_ReadData)
    );

endmodule

//--- dv/flashModel.sv
`timescale 1ns/1ns

module flashModel import flashPkg::*; (
    input  logic     i_FlashClk,
    input  logic     i_FlashNcs,
    inout  wire [3:0] io_FlashIo
);

    // Bytes taken from IO0 in the current or last frame
    logic [DATA_W-1:0] frameBytes[$];
    int                clkCount;
    // Stays high while IO2 reads 1 on every flash clock of the frame
    logic              wpHigh;

    logic [DATA_W-1:0] rxShift;
    int                rxBits;
    int                headerLen;
    logic              readMode;
    logic              misoEn;
    logic              misoBit;
    int                readBit;
    logic [DATA_W-1:0] readIdx;
    logic [DATA_W-1:0] dataByte;

    // Opcode plus address bytes before read data starts, 0 for write-type frames
    function automatic int headerBytes(input logic [DATA_W-1:0] op);
        if (op == OP_READ) begin
            return 4;
        end
        if (op == OP_READ_SR1 || op == OP_READ_SR2 || op == OP_READ_SR3) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic logic [DATA_W-1:0] readValue(input logic [DATA_W-1:0] op,
                                                    input logic [DATA_W-1:0] addrLow,
                                                    input logic [DATA_W-1:0] idx);
        logic [DATA_W-1:0] value;
        case (op)
            OP_READ_SR1: value = 8'hA1;
            OP_READ_SR2: value = 8'hB2;
            OP_READ_SR3: value = 8'hC3;
            default:     value = (addrLow + idx) ^ 8'h5A;
        endcase
        return value;
    endfunction

    // No pullups, the line floats outside read data
    assign io_FlashIo[1] = misoEn ? misoBit : 1'bz;

    initial begin
        clkCount = 0;
        wpHigh   = 1'b0;
        rxShift  = '0;
        rxBits   = 0;
        readMode = 1'b0;
        misoEn   = 1'b0;
        misoBit  = 1'b0;
    end

    always @(negedge i_FlashNcs) begin
        frameBytes.delete();
        clkCount  = 0;
        rxBits    = 0;
        headerLen = 0;
        wpHigh    = 1'b1;
        readMode  = 1'b0;
        readBit   = 0;
        readIdx   = '0;
    end

    always @(posedge i_FlashNcs) begin
        readMode = 1'b0;
        misoEn  <= 1'b0;
    end

    // Command and address bits are sampled on the rising flash clock
    always @(posedge i_FlashClk) begin
        if (i_FlashNcs === 1'b0) begin
            clkCount++;
            wpHigh = wpHigh & (io_FlashIo[2] === 1'b1);
            if (!readMode) begin
                rxShift = {rxShift[DATA_W-2:0], io_FlashIo[0]};
                rxBits++;
                if (rxBits % 8 == 0) begin
                    frameBytes.push_back(rxShift);
                    if (frameBytes.size() == 1) begin
                        headerLen = headerBytes(rxShift);
                    end
                    if (headerLen != 0 && frameBytes.size() == headerLen) begin
                        readMode = 1'b1;
                    end
                end
            end
        end
    end

    // Read data leaves MSB first after each falling flash clock
    always @(negedge i_FlashClk) begin
        if (readMode && i_FlashNcs === 1'b0) begin
            dataByte = readValue(frameBytes[0], frameBytes[frameBytes.size()-1], readIdx);
            misoEn  <= 1'b1;
            misoBit <= dataByte[7-readBit];
            readBit++;
            if (readBit == 8) begin
                readBit = 0;
                readIdx++;
            end
        end
    end

endmodule

//--- dv/flashControllerTb.sv
`timescale 1ns/1ns

module flashControllerTb import flashPkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    // Worst case bytes over write enable, erases, program, read and six status frames
    localparam int FRAME_BYTES    = 1 + 4 + 4 + 1 + 10 + 13 + 6 + 6;
    localparam int FRAME_COUNT    = 12;
    localparam int FRAME_OVERHEAD = 8;
    localparam int TEST_CYCLES    = FRAME_BYTES * 8 + FRAME_COUNT * FRAME_OVERHEAD + 8;
    localparam int WATCHDOG_NS    = TEST_CYCLES * CLK_PERIOD * 3 / 2;

    logic              i_Clk;
    logic              i_arstN;
    logic              cmdEn;
    logic [2:0]        cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] writeData;
    logic              ackReq;
    logic [DATA_W-1:0] readData;
    logic              reqNextData;
    logic              newDataNextClk;
    logic              cmdBusy;
    logic              flashClk;
    logic              flashNcs;
    wire  [3:0]        flashIo;

    logic [31:0]       lfsrState;
    string             testName;
    int                checkCount;
    int                errorCount;
    logic [DATA_W-1:0] expectBytes[$];

    flashController flashController_inst (
        .i_Clk            (i_Clk),
        .i_arstN          (i_arstN),
        .i_CmdEn          (cmdEn),
        .i_Cmd            (cmd),
        .i_Addr           (addr),
        .i_WriteData      (writeData),
        .i_AckReq         (ackReq),
        .o_ReadData       (readData),
        .o_ReqNextData    (reqNextData),
        .o_NewDataNextClk (newDataNextClk),
        .o_CmdBusy        (cmdBusy),
        .o_FlashClk       (flashClk),
        .o_FlashNcs       (flashNcs),
        .io_FlashIo       (flashIo)
    );

    flashModel flashModel_inst (
        .i_FlashClk (flashClk),
        .i_FlashNcs (flashNcs),
        .io_FlashIo (flashIo)
    );

    initial begin
        i_Clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns during test %s", WATCHDOG_NS, testName);
        $display("Simulation failed");
        $finish;
    end

    // Flash clock only runs inside a frame
    assert property (@(posedge i_Clk) disable iff (!i_arstN) flashNcs |-> !flashClk)
        else begin
            errorCount++;
            $display("MISMATCH %s flash clock idle: expected 0 actual %b", testName, flashClk);
        end

    assert property (@(posedge i_Clk) disable iff (!i_arstN) !flashNcs |-> cmdBusy)
        else begin
            errorCount++;
            $display("MISMATCH %s busy in frame: expected 1 actual %b", testName, cmdBusy);
        end

    assert property (@(posedge i_Clk) disable iff (!i_arstN)
                     (reqNextData || newDataNextClk) |-> !flashNcs)
        else begin
            errorCount++;
            $display("MISMATCH %s strobe in frame: expected nCS 0 actual %b", testName, flashNcs);
        end

    // Fibonacci LFSR stepped once per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        assert (actual === expected)
            else begin
                errorCount++;
                $display("MISMATCH %s %s: expected %0h actual %0h",
                         testName, what, expected, actual);
            end
    endtask

    task automatic nextDriveSlot();
        @(posedge i_Clk);
        #(DRIVE_DELAY);
    endtask

    task automatic issueCommand(input cmdT code, input logic [ADDR_W-1:0] address);
        nextDriveSlot();
        cmd   = code;
        addr  = address;
        cmdEn = 1'b1;
        #1;
        compareValue("busy on strobe", 1, cmdBusy);
        nextDriveSlot();
        cmdEn = 1'b0;
    endtask

    task automatic expectAddress(input logic [ADDR_W-1:0] address);
        expectBytes.push_back(address[23:16]);
        expectBytes.push_back(address[15:8]);
        expectBytes.push_back(address[7:0]);
    endtask

    // Acknowledge the first count requests with fresh random bytes
    task automatic serveWrites(input int count, output int requests);
        int sent;
        sent     = 0;
        requests = 0;
        while (flashNcs !== 1'b1) begin
            @(negedge i_Clk);
            if (reqNextData === 1'b1) begin
                requests++;
                if (sent < count) begin
                    nextDriveSlot();
                    writeData = DATA_W'(randomBits(DATA_W));
                    ackReq    = 1'b1;
                    expectBytes.push_back(writeData);
                    sent++;
                    nextDriveSlot();
                    ackReq = 1'b0;
                end
            end
        end
    endtask

    task automatic readStream(input int count, input logic [DATA_W-1:0] addrLow,
                              output int received);
        logic [DATA_W-1:0] expected;
        received = 0;
        while (flashNcs !== 1'b1) begin
            @(negedge i_Clk);
            if (newDataNextClk === 1'b1) begin
                expected = (addrLow + DATA_W'(received)) ^ 8'h5A;
                received++;
                nextDriveSlot();
                compareValue("read byte", expected, readData);
                // Withhold the acknowledge for the last byte
                if (received >= count - 1) begin
                    ackReq = 1'b0;
                end
            end
        end
    endtask

    task automatic closeFrame(input int clocks);
        int frameSize;
        wait (flashNcs === 1'b1);
        nextDriveSlot();
        compareValue("busy after frame", 0, cmdBusy);
        frameSize = flashModel_inst.frameBytes.size();
        compareValue("frame length", expectBytes.size(), frameSize);
        for (int i = 0; i < expectBytes.size() && i < frameSize; i++) begin
            compareValue("frame byte", expectBytes[i], flashModel_inst.frameBytes[i]);
        end
        compareValue("flash clocks", clocks, flashModel_inst.clkCount);
        expectBytes.delete();
    endtask

    initial begin
        int                count;
        int                seen;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] readOp;
        logic [DATA_W-1:0] writeOp;
        logic [DATA_W-1:0] statusValue;
        lfsrState  = 32'h86ba;
        checkCount = 0;
        errorCount = 0;
        testName   = "reset";
        i_arstN    = 1'b0;
        cmdEn      = 1'b0;
        cmd        = WriteEnable;
        addr       = '0;
        writeData  = '0;
        ackReq     = 1'b0;
        repeat (2) @(posedge i_Clk);
        #(DRIVE_DELAY);
        i_arstN = 1'b1;
        nextDriveSlot();
        compareValue("nCS after reset", 1, flashNcs);
        compareValue("strobes after reset", 0, {reqNextData, newDataNextClk, cmdBusy});
        // The gated flash clock can only be high while the system clock is low
        @(negedge i_Clk);
        #(DRIVE_DELAY);
        compareValue("flash clock after reset", 0, flashClk);

        testName = "writeEnable";
        expectBytes.push_back(OP_WRITE_ENABLE);
        issueCommand(WriteEnable, '0);
        closeFrame(8);
        compareValue("write protect high", 1, flashModel_inst.wpHigh);

        testName = "sectorErase";
        address  = ADDR_W'(randomBits(ADDR_W));
        expectBytes.push_back(OP_SECTOR_ERASE);
        expectAddress(address);
        issueCommand(SectorErase, address);
        closeFrame(32);

        testName = "blockErase";
        address  = ADDR_W'(randomBits(ADDR_W));
        expectBytes.push_back(OP_BLOCK_ERASE);
        expectAddress(address);
        issueCommand(BlockErase, address);
        closeFrame(32);

        testName = "chipErase";
        expectBytes.push_back(OP_CHIP_ERASE);
        issueCommand(ChipErase, '0);
        closeFrame(8);

        testName = "pageProgram";
        count    = int'(randomBits(3)) % 6 + 1;
        address  = ADDR_W'(randomBits(ADDR_W));
        expectBytes.push_back(OP_PAGE_PROGRAM);
        expectAddress(address);
        issueCommand(ProgramPage, address);
        serveWrites(count, seen);
        // The declined offer after the last data byte also pulses
        compareValue("request pulses", count + 1, seen);
        closeFrame(8 * (4 + count));

        testName = "read";
        count    = int'(randomBits(3)) + 1;
        address  = ADDR_W'(randomBits(ADDR_W));
        expectBytes.push_back(OP_READ);
        expectAddress(address);
        ackReq = (count > 1);
        issueCommand(Read, address);
        readStream(count, address[7:0], seen);
        compareValue("read bytes", count, seen);
        closeFrame(8 * (4 + count) + READ_TURNAROUND);

        for (int sel = 1; sel <= 3; sel++) begin
            case (sel)
                1: begin
                    readOp      = OP_READ_SR1;
                    writeOp     = OP_WRITE_SR1;
                    statusValue = 8'hA1;
                end
                2: begin
                    readOp      = OP_READ_SR2;
                    writeOp     = OP_WRITE_SR2;
                    statusValue = 8'hB2;
                end
                default: begin
                    readOp      = OP_READ_SR3;
                    writeOp     = OP_WRITE_SR3;
                    statusValue = 8'hC3;
                end
            endcase
            testName = $sformatf("readStatus%0d", sel);
            expectBytes.push_back(readOp);
            issueCommand(ReadSr, ADDR_W'(sel));
            closeFrame(8 * 2 + READ_TURNAROUND);
            compareValue("status value", statusValue, readData);

            testName = $sformatf("writeStatus%0d", sel);
            expectBytes.push_back(writeOp);
            issueCommand(WriteSr, ADDR_W'(sel));
            serveWrites(1, seen);
            compareValue("request pulses", 2, seen);
            closeFrame(16);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/flashPkg.sv
rtl/flashShiftIf.sv
rtl/flashCountIf.sv
rtl/flashBitCounter.sv
rtl/flashShifter.sv
rtl/flashSequencer.sv
rtl/flashController.sv
dv/flashModel.sv
dv/flashControllerTb.sv

//--- Bender.yml
package:
  name: flash_controller

sources:
  - files:
      - rtl/flashPkg.sv
      - rtl/flashShiftIf.sv
      - rtl/flashCountIf.sv
      - rtl/flashBitCounter.sv
      - rtl/flashShifter.sv
      - rtl/flashSequencer.sv
      - rtl/flashController.sv
  - target: test
    files:
      - dv/flashModel.sv
      - dv/flashControllerTb.sv
